// ==== src/fc_event_macros.svh ====
`ifndef FC_EVENT_MACROS_SVH
`define FC_EVENT_MACROS_SVH

// Core interrupt lines and ID width
`define FC_IRQ_NUM      32
`define FC_IRQ_ID_W     5

// Event FIFO geometry
`define FC_EVT_ID_W     8
`define FC_FIFO_DEPTH   4
`define FC_FIFO_PTR_W   2
`define FC_FIFO_CNT_W   3

// Interrupt line raised while the event FIFO holds entries
`define FC_FIFO_PIN     11

// Register port
`define FC_REG_ADDR_W   2
`define FC_REG_DATA_W   32
`define FC_REG_MASK     2'd0
`define FC_REG_PENDING  2'd1
`define FC_REG_CLEAR    2'd2
`define FC_REG_CTRL     2'd3

`endif

// ==== src/fc_irq_pkg.sv ====
`include "fc_event_macros.svh"

package fc_irq_pkg;

  // One bit per core interrupt line
  typedef logic [`FC_IRQ_NUM-1:0] irq_vec_t;

  // Interrupt number, as exchanged with the core
  typedef logic [`FC_IRQ_ID_W-1:0] irq_id_t;

  // Event ID carried by the event FIFO
  typedef logic [`FC_EVT_ID_W-1:0] evt_id_t;

endpackage

// ==== src/fc_core_pkg.sv ====
`include "fc_event_macros.svh"

package fc_core_pkg;

  // Register index and register word of the control port
  typedef logic [`FC_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`FC_REG_DATA_W-1:0] reg_data_t;

  // Core clock gating state
  typedef enum logic {
    WAKE_RUN   = 1'b0,
    WAKE_SLEEP = 1'b1
  } wake_state_t;

endpackage

// ==== src/event_fifo.sv ====
`timescale 1ns/1ps
`include "fc_event_macros.svh"

module event_fifo (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                push_i,
  input  fc_irq_pkg::evt_id_t push_data_i,
  input  logic                pop_i,
  output fc_irq_pkg::evt_id_t head_o,
  output logic                nempty_o,
  output logic                fulln_o
);
  import fc_irq_pkg::*;

  evt_id_t                   mem [`FC_FIFO_DEPTH];
  logic [`FC_FIFO_PTR_W-1:0] wr_ptr_q;
  logic [`FC_FIFO_PTR_W-1:0] rd_ptr_q;
  logic [`FC_FIFO_CNT_W-1:0] count_q;
  logic                      do_push;
  logic                      do_pop;

  assign nempty_o = (count_q != '0);
  assign fulln_o  = (count_q != `FC_FIFO_CNT_W'(`FC_FIFO_DEPTH));
  assign head_o   = mem[rd_ptr_q];

  // Drop pushes when full, ignore pops when empty
  assign do_push = push_i & fulln_o;
  assign do_pop  = pop_i & nempty_o;

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + `FC_FIFO_PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + `FC_FIFO_PTR_W'(1);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + `FC_FIFO_CNT_W'(1);
        2'b01:   count_q <= count_q - `FC_FIFO_CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== src/irq_controller.sv ====
`timescale 1ns/1ps
`include "fc_event_macros.svh"

module irq_controller (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  fc_irq_pkg::irq_vec_t   events_i,
  input  logic                   fifo_nempty_i,
  input  fc_irq_pkg::evt_id_t    fifo_head_i,
  output logic                   fifo_pop_o,
  input  logic                   ack_i,
  input  fc_irq_pkg::irq_id_t    ack_id_i,
  input  logic                   reg_we_i,
  input  logic                   reg_re_i,
  input  fc_core_pkg::reg_addr_t reg_addr_i,
  input  fc_core_pkg::reg_data_t reg_wdata_i,
  output fc_core_pkg::reg_data_t reg_rdata_o,
  input  logic                   fetch_en_i,
  output logic                   fetch_en_o,
  output logic                   irq_req_o,
  output fc_irq_pkg::irq_id_t    irq_id_o
);
  import fc_irq_pkg::*;
  import fc_core_pkg::*;

  irq_vec_t  events_q;
  irq_vec_t  events_prev_q;
  irq_vec_t  event_edge;
  irq_vec_t  pending_q;
  irq_vec_t  pending_d;
  irq_vec_t  pending_eff;
  irq_vec_t  mask_q;
  irq_vec_t  active;
  logic      ctrl_fetch_q;
  logic      ack_fifo;
  reg_data_t rdata_d;

  //******************************
  // Event edge capture
  //******************************
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      events_q      <= '0;
      events_prev_q <= '0;
    end else begin
      events_q      <= events_i;
      events_prev_q <= events_q;
    end
  end

  assign event_edge = events_q & ~events_prev_q;

  // Acknowledge of the FIFO line pops the FIFO
  assign ack_fifo   = ack_i & (ack_id_i == irq_id_t'(`FC_FIFO_PIN));
  assign fifo_pop_o = ack_fifo;

  //******************************
  // Pending update
  //******************************
  always_comb begin
    pending_d = pending_q | event_edge;
    if (reg_we_i && reg_addr_i == `FC_REG_PENDING) begin
      pending_d = pending_d | reg_wdata_i;
    end
    // Clears win over new sets
    if (reg_we_i && reg_addr_i == `FC_REG_CLEAR) begin
      pending_d = pending_d & ~reg_wdata_i;
    end
    if (ack_i && !ack_fifo) begin
      pending_d[ack_id_i] = 1'b0;
    end
    // FIFO line is owned by the FIFO level
    pending_d[`FC_FIFO_PIN] = 1'b0;
  end

  always_comb begin
    pending_eff = pending_q;
    pending_eff[`FC_FIFO_PIN] = fifo_nempty_i;
  end

  assign active = pending_eff & mask_q;

  // Highest numbered active line wins
  always_comb begin
    irq_req_o = |active;
    irq_id_o  = '0;
    for (int i = 0; i < `FC_IRQ_NUM; i++) begin
      if (active[i]) begin
        irq_id_o = irq_id_t'(i);
      end
    end
  end

  //******************************
  // Register port
  //******************************
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q    <= '0;
      mask_q       <= '0;
      ctrl_fetch_q <= 1'b0;
    end else begin
      pending_q <= pending_d;
      if (reg_we_i) begin
        case (reg_addr_i)
          `FC_REG_MASK: mask_q       <= reg_wdata_i;
          `FC_REG_CTRL: ctrl_fetch_q <= reg_wdata_i[0];
          default:      ;
        endcase
      end
    end
  end

  always_comb begin
    case (reg_addr_i)
      `FC_REG_MASK:    rdata_d = mask_q;
      `FC_REG_PENDING: rdata_d = pending_eff;
      `FC_REG_CLEAR:   rdata_d = reg_data_t'(fifo_head_i);
      default:         rdata_d = {{(`FC_REG_DATA_W-1){1'b0}}, ctrl_fetch_q};
    endcase
  end

  // Read data lands one cycle after the strobe
  always_ff @(posedge clk_i) begin
    if (reg_re_i) begin
      reg_rdata_o <= rdata_d;
    end
  end

  assign fetch_en_o = ctrl_fetch_q & fetch_en_i;

endmodule

// ==== src/core_wake_ctrl.sv ====
`timescale 1ns/1ps

module core_wake_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 irq_req_i,
  input  fc_irq_pkg::irq_id_t  irq_id_i,
  input  logic                 sleep_req_i,
  output fc_irq_pkg::irq_vec_t irq_o,
  output logic                 core_clock_en_o
);
  import fc_irq_pkg::*;
  import fc_core_pkg::*;

  irq_vec_t    irq_d;
  wake_state_t state_q;
  wake_state_t state_d;

  //******************************
  // ID back to one-hot lines
  //******************************
  always_comb begin
    irq_d = '0;
    if (irq_req_i) begin
      irq_d[irq_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      irq_o <= '0;
    end else begin
      irq_o <= irq_d;
    end
  end

  //******************************
  // Sleep FSM
  //******************************
  always_comb begin
    state_d = state_q;
    case (state_q)
      WAKE_RUN: begin
        // Sleep only with nothing to serve
        if (sleep_req_i && !irq_req_i) begin
          state_d = WAKE_SLEEP;
        end
      end
      WAKE_SLEEP: begin
        if (irq_req_i) begin
          state_d = WAKE_RUN;
        end
      end
      default: state_d = WAKE_RUN;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= WAKE_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  assign core_clock_en_o = (state_q == WAKE_RUN);

endmodule

// ==== src/fc_event_subsystem.sv ====
`timescale 1ns/1ps

module fc_event_subsystem (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   event_fifo_valid_i,
  input  fc_irq_pkg::evt_id_t    event_fifo_data_i,
  output logic                   event_fifo_fulln_o,
  input  fc_irq_pkg::irq_vec_t   events_i,
  input  logic                   irq_ack_i,
  input  fc_irq_pkg::irq_id_t    irq_ack_id_i,
  input  logic                   sleep_req_i,
  input  logic                   fetch_en_i,
  input  logic                   reg_we_i,
  input  logic                   reg_re_i,
  input  fc_core_pkg::reg_addr_t reg_addr_i,
  input  fc_core_pkg::reg_data_t reg_wdata_i,
  output fc_core_pkg::reg_data_t reg_rdata_o,
  output fc_irq_pkg::irq_vec_t   irq_o,
  output logic                   core_clock_en_o,
  output logic                   fetch_en_o
);
  import fc_irq_pkg::*;

  logic    fifo_nempty;
  logic    fifo_pop;
  evt_id_t fifo_head;
  logic    irq_req;
  irq_id_t irq_id;

  // Input side
  event_fifo u_event_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .push_i      (event_fifo_valid_i),
    .push_data_i (event_fifo_data_i),
    .pop_i       (fifo_pop),
    .head_o      (fifo_head),
    .nempty_o    (fifo_nempty),
    .fulln_o     (event_fifo_fulln_o)
  );

  // Pending, mask and arbitration
  irq_controller u_irq_controller (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .events_i      (events_i),
    .fifo_nempty_i (fifo_nempty),
    .fifo_head_i   (fifo_head),
    .fifo_pop_o    (fifo_pop),
    .ack_i         (irq_ack_i),
    .ack_id_i      (irq_ack_id_i),
    .reg_we_i      (reg_we_i),
    .reg_re_i      (reg_re_i),
    .reg_addr_i    (reg_addr_i),
    .reg_wdata_i   (reg_wdata_i),
    .reg_rdata_o   (reg_rdata_o),
    .fetch_en_i    (fetch_en_i),
    .fetch_en_o    (fetch_en_o),
    .irq_req_o     (irq_req),
    .irq_id_o      (irq_id)
  );

  // Output side towards the core
  core_wake_ctrl u_core_wake_ctrl (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .irq_req_i       (irq_req),
    .irq_id_i        (irq_id),
    .sleep_req_i     (sleep_req_i),
    .irq_o           (irq_o),
    .core_clock_en_o (core_clock_en_o)
  );

endmodule

// ==== bench/fc_event_subsystem_asserts.sv ====
`timescale 1ns/1ps

module fc_event_subsystem_asserts (
  input logic                 clk_i,
  input logic                 rst_i,
  input fc_irq_pkg::irq_vec_t irq_i,
  input logic                 clock_en_i,
  input logic                 fulln_i,
  input logic                 fifo_nempty_i
);

  // At most one line towards the core
  irq_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(irq_i))
    else $error("irq_o has more than one line set");

  // A core that sees an interrupt is clocked
  irq_clocked: assert property (@(posedge clk_i) disable iff (rst_i)
    (irq_i != '0) |-> clock_en_i)
    else $error("irq_o is set while the core clock is gated");

  // Full implies at least one entry
  fifo_full_nempty: assert property (@(posedge clk_i) disable iff (rst_i)
    !(!fulln_i && !fifo_nempty_i))
    else $error("event FIFO reports full while empty");

endmodule

bind fc_event_subsystem fc_event_subsystem_asserts u_asserts (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .irq_i         (irq_o),
  .clock_en_i    (core_clock_en_o),
  .fulln_i       (event_fifo_fulln_o),
  .fifo_nempty_i (fifo_nempty)
);

// ==== bench/fc_event_subsystem_tb.sv ====
`timescale 1ns/1ps
`include "fc_event_macros.svh"

module fc_event_subsystem_tb;
  import fc_irq_pkg::*;
  import fc_core_pkg::*;

  localparam int TIMEOUT_CYCLES = 50;

  logic      clk_i;
  logic      rst_i;
  logic      event_fifo_valid_i;
  evt_id_t   event_fifo_data_i;
  logic      event_fifo_fulln_o;
  irq_vec_t  events_i;
  logic      irq_ack_i;
  irq_id_t   irq_ack_id_i;
  logic      sleep_req_i;
  logic      fetch_en_i;
  logic      reg_we_i;
  logic      reg_re_i;
  reg_addr_t reg_addr_i;
  reg_data_t reg_wdata_i;
  reg_data_t reg_rdata_o;
  irq_vec_t  irq_o;
  logic      core_clock_en_o;
  logic      fetch_en_o;

  int errors;
  int checks;
  int test_id;

  // Lines the core is expected to see, taken from the trace
  irq_vec_t irq_expected;

  fc_event_subsystem DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset_values";
      2:       return "edge_mask_priority";
      3:       return "software_set_clear";
      4:       return "event_fifo";
      5:       return "back_pressure";
      6:       return "sleep_wake";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: %s expected %h actual %h",
               test_name(test_id), what, expected, actual);
    end
  endtask

  //******************************
  // Core side operations
  //******************************
  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    @(negedge clk_i);
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(negedge clk_i);
    reg_we_i = 1'b0;
  endtask

  // Read data is registered, so it is sampled one falling edge later
  task automatic reg_read_check(input reg_addr_t addr, input reg_data_t expected);
    @(negedge clk_i);
    reg_re_i   = 1'b1;
    reg_addr_i = addr;
    @(negedge clk_i);
    reg_re_i = 1'b0;
    check_value("reg_rdata_o", expected, reg_rdata_o);
  endtask

  task automatic push_event(input evt_id_t id);
    @(negedge clk_i);
    event_fifo_valid_i = 1'b1;
    event_fifo_data_i  = id;
    @(negedge clk_i);
    event_fifo_valid_i = 1'b0;
  endtask

  task automatic ack_irq(input irq_id_t id);
    @(negedge clk_i);
    irq_ack_i    = 1'b1;
    irq_ack_id_i = id;
    @(negedge clk_i);
    irq_ack_i = 1'b0;
  endtask

  // Sleep is refused while an interrupt is requested
  task automatic request_sleep();
    @(negedge clk_i);
    sleep_req_i = 1'b1;
    @(negedge clk_i);
    sleep_req_i = 1'b0;
    check_value("core_clock_en_o", 32'(irq_expected != '0), 32'(core_clock_en_o));
  endtask

  //******************************
  // Bounded waits
  //******************************
  task automatic wait_irq(input irq_vec_t expected);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (irq_o !== expected && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
    end
    checks++;
    if (irq_o !== expected) begin
      errors++;
      $display("Timeout in %s: irq_o never became %h, it is still %h",
               test_name(test_id), expected, irq_o);
    end
  endtask

  task automatic wait_clock_en(input logic expected);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (core_clock_en_o !== expected && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
    end
    checks++;
    if (core_clock_en_o !== expected) begin
      errors++;
      $display("Timeout in %s: core_clock_en_o never became %b",
               test_name(test_id), expected);
    end
  endtask

  // One trace line
  task automatic run_op(input byte op, input logic [31:0] arg_a, input logic [31:0] arg_b);
    case (op)
      "T": test_id = int'(arg_a);
      "W": reg_write(arg_a[`FC_REG_ADDR_W-1:0], arg_b);
      "R": reg_read_check(arg_a[`FC_REG_ADDR_W-1:0], arg_b);
      "E": begin
        @(negedge clk_i);
        events_i = arg_a;
      end
      "F": begin
        @(negedge clk_i);
        fetch_en_i = arg_a[0];
      end
      "P": push_event(arg_a[`FC_EVT_ID_W-1:0]);
      "A": ack_irq(arg_a[`FC_IRQ_ID_W-1:0]);
      "S": request_sleep();
      "D": repeat (arg_a) @(negedge clk_i);
      "I": begin
        irq_expected = arg_a;
        wait_irq(arg_a);
      end
      "C": wait_clock_en(arg_a[0]);
      "Q": begin
        irq_expected = arg_a;
        @(negedge clk_i);
        check_value("irq_o", arg_a, irq_o);
      end
      "N": begin
        @(negedge clk_i);
        check_value("event_fifo_fulln_o", arg_a, 32'(event_fifo_fulln_o));
      end
      "O": begin
        @(negedge clk_i);
        check_value("fetch_en_o", arg_a, 32'(fetch_en_o));
      end
      default: begin
        errors++;
        $display("Unknown operation '%c' in the trace file", op);
      end
    endcase
  endtask

  initial begin
    int          fd;
    string       line;
    byte         op;
    logic [31:0] arg_a;
    logic [31:0] arg_b;
    errors             = 0;
    checks             = 0;
    test_id            = 0;
    irq_expected       = '0;
    rst_i              = 1'b1;
    event_fifo_valid_i = 1'b0;
    event_fifo_data_i  = '0;
    events_i           = '0;
    irq_ack_i          = 1'b0;
    irq_ack_id_i       = '0;
    sleep_req_i        = 1'b0;
    fetch_en_i         = 1'b0;
    reg_we_i           = 1'b0;
    reg_re_i           = 1'b0;
    reg_addr_i         = '0;
    reg_wdata_i        = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    fd = $fopen("bench/fc_event_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the trace file bench/fc_event_trace.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Skip comments and blank lines
        if (line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        if ($sscanf(line, "%c %h %h", op, arg_a, arg_b) != 3) begin
          errors++;
          $display("Trace line is not in the form op arg_a arg_b: %s", line);
        end else begin
          run_op(op, arg_a, arg_b);
        end
      end
      $fclose(fd);
    end

    $display("Finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== bench/fc_event_trace.txt ====
# Columns: op arg_a arg_b, values in hex, unused arguments are 0
# T test, W/R reg write/read (addr, data), E events_i, F fetch_en_i, P push, A ack, S sleep,
# D idle cycles, I/C wait for irq_o/clock enable, Q/N/O check irq_o/fulln/fetch_en_o now
T 1 0
Q 0 0
C 1 0
N 1 0
O 0 0
F 1 0
O 0 0
W 3 1
O 1 0
F 0 0
O 0 0
T 2 0
E 00100008 0
D 3 0
R 1 00100008
Q 0 0
W 0 ffffffff
I 00100000 0
A 14 0
I 00000008 0
A 3 0
I 0 0
E 0 0
T 3 0
W 1 00000100
I 00000100 0
W 2 00000100
I 0 0
R 1 0
T 4 0
P 21 0
P 5a 0
I 00000800 0
N 1 0
R 2 21
A b 0
R 2 5a
Q 00000800 0
A b 0
I 0 0
T 5 0
P 1 0
P 2 0
P 3 0
N 1 0
P 4 0
N 0 0
P 5 0
N 0 0
R 2 1
A b 0
R 2 2
A b 0
R 2 3
A b 0
R 2 4
A b 0
I 0 0
N 1 0
R 1 0
T 6 0
S 0 0
C 0 0
E 00010000 0
C 1 0
Q 00010000 0
A 10 0
I 0 0
W 1 00000200
I 00000200 0
S 0 0
D 2 0
C 1 0
W 2 00000200
I 0 0
E 0 0

// ==== fc_event_subsystem.f ====
+incdir+src
src/fc_irq_pkg.sv
src/fc_core_pkg.sv
src/event_fifo.sv
src/irq_controller.sv
src/core_wake_ctrl.sv
src/fc_event_subsystem.sv
bench/fc_event_subsystem_asserts.sv
bench/fc_event_subsystem_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = fc_event_subsystem_tb
FILELIST = fc_event_subsystem.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
